// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int xlen    = 64;
    localparam int instr_w = 32;
    localparam int shamt_w = $clog2(xlen);                  // 6 shamt bits on rv64

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_alu  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add_sub = 3'b000;             // also addi
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;             // also slti
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_ld      = 3'b011;
    localparam logic [2:0] f3_sd      = 3'b011;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_jalr    = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;           // sub

    // shift immediates keep only the upper bits above shamt
    localparam logic [instr_w-shamt_w-21:0] f6_logical = 6'b000000;
    localparam logic [instr_w-shamt_w-21:0] f6_arith   = 6'b010000;

    typedef enum logic [4:0] {
        st_reset,
        st_fetch_wait,
        st_fetch,
        st_decode,
        st_execute,
        st_write_alu,
        st_write_slt_one,
        st_write_slt_zero,
        st_lui_write,
        st_jal_pc,
        st_jalr_link,
        st_load_wait,
        st_load_read,
        st_load_capture,
        st_load_write,
        st_store_read,
        st_store_wait,
        st_store_write,
        st_trap_illegal,
        st_trap_overflow,
        st_trap_vector,
        st_halt
    } ctrl_state_e;

    typedef enum logic [3:0] {
        cls_r_alu, cls_slt, cls_i_alu, cls_slti, cls_shift, cls_load, cls_store,
        cls_branch, cls_lui, cls_jal, cls_jalr, cls_break, cls_illegal
    } instr_class_e;

    typedef enum logic [2:0] {alu_nop, alu_add, alu_sub, alu_and, alu_ge, alu_slt} alu_op_e;

    typedef enum logic [1:0] {br_eq, br_ne, br_lt, br_ge} branch_cond_e;

    typedef enum logic [1:0] {sh_sll, sh_srl, sh_sra} shift_op_e;

    typedef enum logic [1:0] {src_a_pc, src_a_reg, src_a_zero} alu_src_a_e;

    typedef enum logic [2:0] {src_b_reg, src_b_four, src_b_imm, src_b_imm_shifted} alu_src_b_e;

    typedef enum logic [2:0] {wb_alu_out, wb_one, wb_zero, wb_pc, wb_mem, wb_shift} wb_sel_e;

    typedef enum logic [1:0] {pc_alu_result, pc_alu_out, pc_trap_vector} pc_src_e;

    typedef enum logic [1:0] {addr_alu_out, addr_illegal_vec, addr_overflow_vec} mem_addr_e;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic [ctrl_pkg::instr_w-1:0] instr,
    output ctrl_pkg::instr_class_e       instr_class,
    output ctrl_pkg::alu_op_e            alu_op,
    output ctrl_pkg::branch_cond_e       branch_cond,
    output ctrl_pkg::shift_op_e          shift_op
);
    import ctrl_pkg::*;

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [instr_w-shamt_w-21:0] funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[instr_w-1:20+shamt_w];            // bits above the 6-bit shamt

    always_comb begin
        instr_class = cls_illegal;                          // anything unmatched traps
        alu_op      = alu_nop;
        branch_cond = br_eq;
        shift_op    = sh_sll;
        case (opcode)
            op_r_type: begin
                if (funct7 == f7_base && funct3 == f3_add_sub) begin
                    instr_class = cls_r_alu;
                    alu_op      = alu_add;
                end else if (funct7 == f7_alt && funct3 == f3_add_sub) begin
                    instr_class = cls_r_alu;
                    alu_op      = alu_sub;
                end else if (funct7 == f7_base && funct3 == f3_and) begin
                    instr_class = cls_r_alu;
                    alu_op      = alu_and;
                end else if (funct7 == f7_base && funct3 == f3_slt) begin
                    instr_class = cls_slt;
                    alu_op      = alu_slt;
                end
            end
            op_i_alu: begin
                if (funct3 == f3_add_sub) begin             // addi, all-zero word included
                    instr_class = cls_i_alu;
                    alu_op      = alu_add;
                end else if (funct3 == f3_slt) begin
                    instr_class = cls_slti;
                    alu_op      = alu_slt;
                end else if (funct3 == f3_sll && funct6 == f6_logical) begin
                    instr_class = cls_shift;
                    shift_op    = sh_sll;
                end else if (funct3 == f3_srl_sra && funct6 == f6_logical) begin
                    instr_class = cls_shift;
                    shift_op    = sh_srl;
                end else if (funct3 == f3_srl_sra && funct6 == f6_arith) begin
                    instr_class = cls_shift;
                    shift_op    = sh_sra;
                end
            end
            op_load: begin
                if (funct3 == f3_ld) begin                  // ld only
                    instr_class = cls_load;
                    alu_op      = alu_add;
                end
            end
            op_store: begin
                if (funct3 == f3_sd) begin
                    instr_class = cls_store;
                    alu_op      = alu_add;
                end
            end
            op_branch: begin
                instr_class = cls_branch;
                alu_op      = alu_sub;
                case (funct3)
                    f3_beq: branch_cond = br_eq;
                    f3_bne: branch_cond = br_ne;
                    f3_blt: branch_cond = br_lt;
                    f3_bge: begin
                        branch_cond = br_ge;
                        alu_op      = alu_ge;
                    end
                    default: begin
                        instr_class = cls_illegal;
                        alu_op      = alu_nop;
                    end
                endcase
            end
            op_jalr: begin
                if (funct3 == f3_jalr) begin
                    instr_class = cls_jalr;
                    alu_op      = alu_add;
                end
            end
            op_lui: begin
                instr_class = cls_lui;
                alu_op      = alu_add;                      // zero + imm
            end
            op_jal:    instr_class = cls_jal;
            op_system: instr_class = cls_break;
            default:   instr_class = cls_illegal;
        endcase
    end

endmodule

// ==== logic/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                   CLK,
    input  logic                   RST,
    input  ctrl_pkg::instr_class_e instr_class,
    input  logic                   less,
    input  logic                   overflow,
    output ctrl_pkg::ctrl_state_e  state
);
    import ctrl_pkg::*;

    ctrl_state_e next_state;
    logic        ovf_class;

    // only these classes can raise an arithmetic trap
    assign ovf_class = (instr_class == cls_r_alu) || (instr_class == cls_i_alu) ||
                       (instr_class == cls_jalr);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset:      next_state = st_fetch_wait;
            st_fetch_wait: next_state = st_fetch;
            st_fetch:      next_state = st_decode;
            st_decode:     next_state = st_execute;
            st_execute: begin
                case (instr_class)
                    cls_r_alu,
                    cls_i_alu:   next_state = st_write_alu;
                    cls_slt,
                    cls_slti: begin
                        if (less) begin
                            next_state = st_write_slt_one;
                        end else begin
                            next_state = st_write_slt_zero;
                        end
                    end
                    cls_load:    next_state = st_load_wait;
                    cls_store:   next_state = st_store_read;
                    cls_lui:     next_state = st_lui_write;
                    cls_jal:     next_state = st_jal_pc;
                    cls_jalr:    next_state = st_jalr_link;
                    cls_shift,
                    cls_branch:  next_state = st_fetch_wait;   // done in execute
                    cls_break:   next_state = st_halt;
                    default:     next_state = st_trap_illegal;
                endcase
                if (overflow && ovf_class) begin
                    next_state = st_trap_overflow;           // overrides the class path
                end
            end
            st_write_alu,
            st_write_slt_one,
            st_write_slt_zero,
            st_lui_write,
            st_jal_pc,
            st_jalr_link:    next_state = st_fetch_wait;
            st_load_wait:    next_state = st_load_read;
            st_load_read:    next_state = st_load_capture;
            st_load_capture: next_state = st_load_write;
            st_load_write:   next_state = st_fetch_wait;
            st_store_read:   next_state = st_store_wait;
            st_store_wait:   next_state = st_store_write;
            st_store_write:  next_state = st_fetch_wait;
            st_trap_illegal,
            st_trap_overflow: next_state = st_trap_vector;
            st_trap_vector:  next_state = st_fetch_wait;
            st_halt:         next_state = st_halt;       // only reset leaves
            default:         next_state = st_reset;
        endcase
    end

endmodule

// ==== logic/ctrl_signal_gen.sv ====
`timescale 1ns/1ps

module ctrl_signal_gen (
    input  ctrl_pkg::ctrl_state_e  state,
    input  ctrl_pkg::instr_class_e instr_class,
    input  ctrl_pkg::alu_op_e      alu_op,
    input  ctrl_pkg::branch_cond_e branch_cond,
    input  ctrl_pkg::shift_op_e    shift_op,
    input  logic                   zero,
    input  logic                   less,
    output ctrl_pkg::alu_op_e      alu_ctrl,
    output ctrl_pkg::alu_src_a_e   alu_src_a,
    output ctrl_pkg::alu_src_b_e   alu_src_b,
    output ctrl_pkg::pc_src_e      pc_src,
    output logic                   pc_write,
    output logic                   ir_load,
    output logic                   ab_write,
    output logic                   alu_out_write,
    output logic                   reg_write,
    output ctrl_pkg::wb_sel_e      wb_sel,
    output ctrl_pkg::mem_addr_e    mem_addr_sel,
    output logic                   mem_write,
    output logic                   mdr_write,
    output logic                   epc_write,
    output ctrl_pkg::shift_op_e    shift_ctrl
);
    import ctrl_pkg::*;

    logic branch_taken;

    always_comb begin
        case (branch_cond)
            br_eq:   branch_taken = zero;
            br_ne:   branch_taken = !zero;
            br_lt:   branch_taken = less;
            default: branch_taken = !less;                 // bge
        endcase
    end

    always_comb begin
        alu_ctrl      = alu_nop;
        alu_src_a     = src_a_pc;
        alu_src_b     = src_b_reg;
        pc_src        = pc_alu_result;
        pc_write      = 1'b0;
        ir_load       = 1'b0;
        ab_write      = 1'b0;
        alu_out_write = 1'b0;
        reg_write     = 1'b0;
        wb_sel        = wb_alu_out;
        mem_addr_sel  = addr_alu_out;
        mem_write     = 1'b0;
        mdr_write     = 1'b0;
        epc_write     = 1'b0;
        shift_ctrl    = sh_sll;
        case (state)
            st_fetch: begin
                ir_load   = 1'b1;
                pc_write  = 1'b1;
                alu_ctrl  = alu_add;                         // pc + 4
                alu_src_b = src_b_four;
            end
            st_decode: begin
                ab_write      = 1'b1;
                alu_out_write = 1'b1;                        // speculative branch/jal target
                alu_ctrl      = alu_add;
                alu_src_b     = src_b_imm_shifted;
            end
            st_execute: begin
                alu_ctrl = alu_op;
                case (instr_class)
                    cls_r_alu, cls_slt, cls_branch: begin
                        alu_src_a = src_a_reg;
                        alu_src_b = src_b_reg;
                    end
                    cls_i_alu, cls_slti, cls_load, cls_store, cls_jalr: begin
                        alu_src_a = src_a_reg;
                        alu_src_b = src_b_imm;
                    end
                    cls_lui: begin
                        alu_src_a = src_a_zero;
                        alu_src_b = src_b_imm;
                    end
                    cls_shift: begin
                        reg_write  = 1'b1;
                        wb_sel     = wb_shift;
                        shift_ctrl = shift_op;
                    end
                    default: ;
                endcase
                alu_out_write = (instr_class == cls_r_alu) || (instr_class == cls_i_alu) ||
                                (instr_class == cls_load) || (instr_class == cls_store) ||
                                (instr_class == cls_lui) || (instr_class == cls_jalr);
                if (instr_class == cls_branch) begin
                    pc_write = branch_taken;
                    pc_src   = pc_alu_out;                    // target from decode
                end
            end
            st_write_alu,
            st_lui_write: begin
                reg_write = 1'b1;
                wb_sel    = wb_alu_out;
            end
            st_write_slt_one: begin
                reg_write = 1'b1;
                wb_sel    = wb_one;
            end
            st_write_slt_zero: begin
                reg_write = 1'b1;
                wb_sel    = wb_zero;
            end
            st_jal_pc,
            st_jalr_link: begin
                reg_write = 1'b1;
                wb_sel    = wb_pc;                           // link is pc + 4
                pc_write  = 1'b1;
                pc_src    = pc_alu_out;
            end
            st_load_capture: mdr_write = 1'b1;
            st_load_write: begin
                reg_write = 1'b1;
                wb_sel    = wb_mem;
            end
            st_store_write: mem_write = 1'b1;
            st_trap_illegal,
            st_trap_overflow: begin
                epc_write = 1'b1;
                mdr_write = 1'b1;                            // vector byte from memory
                alu_ctrl  = alu_sub;                         // pc - 4 into epc
                alu_src_b = src_b_four;
                if (state == st_trap_illegal) begin
                    mem_addr_sel = addr_illegal_vec;
                end else begin
                    mem_addr_sel = addr_overflow_vec;
                end
            end
            st_trap_vector: begin
                pc_write = 1'b1;
                pc_src   = pc_trap_vector;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/multicycle_ctrl.sv ====
`timescale 1ns/1ps

module multicycle_ctrl (
    input  logic                         CLK,
    input  logic                         RST,
    input  logic [ctrl_pkg::instr_w-1:0] instr,
    input  logic                         zero,
    input  logic                         less,
    input  logic                         overflow,
    output ctrl_pkg::alu_op_e            alu_ctrl,
    output ctrl_pkg::alu_src_a_e         alu_src_a,
    output ctrl_pkg::alu_src_b_e         alu_src_b,
    output ctrl_pkg::pc_src_e            pc_src,
    output logic                         pc_write,
    output logic                         ir_load,
    output logic                         ab_write,
    output logic                         alu_out_write,
    output logic                         reg_write,
    output ctrl_pkg::wb_sel_e            wb_sel,
    output ctrl_pkg::mem_addr_e          mem_addr_sel,
    output logic                         mem_write,
    output logic                         mdr_write,
    output logic                         epc_write,
    output ctrl_pkg::shift_op_e          shift_ctrl
);
    import ctrl_pkg::*;

    instr_class_e instr_class;
    alu_op_e      alu_op;
    branch_cond_e branch_cond;
    shift_op_e    shift_op;
    ctrl_state_e  state;

    instr_decoder decoder_i (
        .instr       (instr),
        .instr_class (instr_class),
        .alu_op      (alu_op),
        .branch_cond (branch_cond),
        .shift_op    (shift_op)
    );

    ctrl_sequencer sequencer_i (
        .CLK         (CLK),
        .RST         (RST),
        .instr_class (instr_class),
        .less        (less),
        .overflow    (overflow),
        .state       (state)
    );

    ctrl_signal_gen signal_gen_i (
        .state         (state),
        .instr_class   (instr_class),
        .alu_op        (alu_op),
        .branch_cond   (branch_cond),
        .shift_op      (shift_op),
        .zero          (zero),
        .less          (less),
        .alu_ctrl      (alu_ctrl),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .pc_src        (pc_src),
        .pc_write      (pc_write),
        .ir_load       (ir_load),
        .ab_write      (ab_write),
        .alu_out_write (alu_out_write),
        .reg_write     (reg_write),
        .wb_sel        (wb_sel),
        .mem_addr_sel  (mem_addr_sel),
        .mem_write     (mem_write),
        .mdr_write     (mdr_write),
        .epc_write     (epc_write),
        .shift_ctrl    (shift_ctrl)
    );

endmodule

// ==== verification/multicycle_ctrl_assert.sv ====
`timescale 1ns/1ps

module multicycle_ctrl_assert (
    input logic              CLK,
    input logic              RST,
    input logic              ir_load,
    input logic              pc_write,
    input logic              reg_write,
    input logic              mem_write,
    input logic              epc_write,
    input ctrl_pkg::pc_src_e pc_src
);
    import ctrl_pkg::*;

    int assert_errors = 0;                                  // read by the testbench

    fetch_updates_pc: assert property (@(posedge CLK) disable iff (RST)
        ir_load |-> pc_write)
    else begin
        $error("ir_load without pc_write");
        assert_errors++;
    end

    no_mem_and_reg_write: assert property (@(posedge CLK) disable iff (RST)
        !(mem_write && reg_write))
    else begin
        $error("mem_write and reg_write high together");
        assert_errors++;
    end

    // trap entry is always followed by the jump to the vector
    epc_then_vector: assert property (@(posedge CLK) disable iff (RST)
        epc_write |=> (pc_write && pc_src == pc_trap_vector))
    else begin
        $error("epc_write not followed by pc_write to the trap vector");
        assert_errors++;
    end

endmodule

bind multicycle_ctrl multicycle_ctrl_assert assert_i (
    .CLK       (CLK),
    .RST       (RST),
    .ir_load   (ir_load),
    .pc_write  (pc_write),
    .reg_write (reg_write),
    .mem_write (mem_write),
    .epc_write (epc_write),
    .pc_src    (pc_src)
);

// ==== verification/multicycle_ctrl_tb.sv ====
`timescale 1ns/1ps

module multicycle_ctrl_tb;
    import ctrl_pkg::*;

    localparam int max_tests  = 64;
    localparam int cols       = 10;
    localparam int step_limit = 16;                         // longest legal path is 8
    localparam int halt_watch = 10;

    logic               CLK;
    logic               RST;
    logic [instr_w-1:0] instr;
    logic               zero;
    logic               less;
    logic               overflow;

    alu_op_e      alu_ctrl;
    alu_src_a_e   alu_src_a;
    alu_src_b_e   alu_src_b;
    pc_src_e      pc_src;
    logic         pc_write;
    logic         ir_load;
    logic         ab_write;
    logic         alu_out_write;
    logic         reg_write;
    wb_sel_e      wb_sel;
    mem_addr_e    mem_addr_sel;
    logic         mem_write;
    logic         mdr_write;
    logic         epc_write;
    shift_op_e    shift_ctrl;

    logic [31:0] test_mem [0:max_tests*cols];
    int          test_count;
    logic        loaded = 1'b0;
    int          cur_test;
    int          error_count;
    int          obs_cycles;
    alu_op_e     obs_alu;
    wb_sel_e     obs_wb;
    pc_src_e     obs_pc;
    shift_op_e   obs_shift;
    mem_addr_e   obs_addr;
    logic        obs_ab;
    logic        obs_aout;
    logic        wb_seen;
    logic        pc_seen;
    logic        fetched;
    alu_op_e     fetch_alu;
    pc_src_e     fetch_pc;
    alu_src_a_e  fetch_a;
    alu_src_b_e  fetch_b;
    int          mem_cnt;
    int          epc_cnt;

    multicycle_ctrl dut_i (.*);

    always #4 CLK = ~CLK;

    task automatic check_cycles(input string name, input int exp, input int got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_wb(input string name, input wb_sel_e exp, input wb_sel_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_pc_src(input string name, input pc_src_e exp, input pc_src_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_shift(input string name, input shift_op_e exp, input shift_op_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_e exp, input mem_addr_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_src_a(input string name, input alu_src_a_e exp, input alu_src_a_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    task automatic check_src_b(input string name, input alu_src_b_e exp, input alu_src_b_e got);
        if (got !== exp) begin
            $display("FAIL %s: expected 0x%h, got 0x%h (test %0d)", name, exp, got, cur_test);
            error_count++;
        end
    endtask

    // funct3 picks the direction, instr[30] marks the arithmetic right shift
    function automatic shift_op_e shift_kind(input logic [31:0] word);
        if (word[14:12] == 3'b001) return sh_sll;
        if (word[30]) return sh_sra;
        return sh_srl;
    endfunction

    function automatic logic strobes_active();
        return ir_load | pc_write | reg_write | mem_write | mdr_write | alu_out_write |
               ab_write | epc_write;
    endfunction

    // cycle 1 is decode, cycle 2 execute, the fetch that ends the test is not recorded
    task automatic observe(input int limit);
        obs_cycles = 0;
        obs_alu    = alu_nop;
        obs_wb     = wb_alu_out;
        obs_pc     = pc_alu_result;
        obs_shift  = sh_sll;
        obs_addr   = addr_alu_out;
        obs_ab     = 1'b0;
        obs_aout   = 1'b0;
        wb_seen    = 1'b0;
        pc_seen    = 1'b0;
        fetched    = 1'b0;
        mem_cnt    = 0;
        epc_cnt    = 0;
        while (!fetched && obs_cycles < limit) begin
            @(posedge CLK);
            obs_cycles++;
            if (ir_load) begin
                fetched   = 1'b1;
                fetch_alu = alu_ctrl;
                fetch_pc  = pc_src;
                fetch_a   = alu_src_a;
                fetch_b   = alu_src_b;
            end else begin
                if (obs_cycles == 1) begin
                    obs_ab   = ab_write;
                    obs_aout = alu_out_write;
                end
                if (obs_cycles == 2) obs_alu = alu_ctrl;
                if (reg_write) begin
                    wb_seen   = 1'b1;
                    obs_wb    = wb_sel;
                    obs_shift = shift_ctrl;
                end
                if (pc_write) begin
                    pc_seen = 1'b1;
                    obs_pc  = pc_src;
                end
                if (mem_write) mem_cnt++;
                if (epc_write) begin
                    epc_cnt++;
                    obs_addr = mem_addr_sel;
                end
            end
        end
    endtask

    // the whole run may take at most 20 cycles per test
    initial begin
        wait (loaded);
        repeat (test_count * 20 + 8) @(posedge CLK);
        $display("watchdog expired after %0d cycles", test_count * 20 + 8);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int          base;
        int          idle;
        int          tests_run;
        int          tests_failed;
        int          errs_before;
        logic        early;
        logic        running;
        logic [31:0] exp_cycles;
        logic [31:0] exp_wb;
        logic [31:0] exp_pc;
        mem_addr_e   exp_addr;

        CLK          = 1'b0;
        RST          = 1'b1;
        instr        = '0;
        zero         = 1'b0;
        less         = 1'b0;
        overflow     = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = 0;
        early        = 1'b0;
        running      = 1'b1;
        $readmemh("verification/ctrl_tests.txt", test_mem);
        test_count = test_mem[0];
        loaded     = 1'b1;

        repeat (4) begin
            @(posedge CLK);
            if (strobes_active()) early = 1'b1;
        end
        RST  <= 1'b0;
        idle = 0;
        @(posedge CLK);
        while (!ir_load && idle < step_limit) begin
            if (strobes_active()) early = 1'b1;
            idle++;
            @(posedge CLK);
        end
        check_strobe("early_strobe", 1'b0, early);
        check_cycles("reset_to_fetch", 2, idle);
        if (!ir_load) running = 1'b0;

        for (int t = 0; t < test_count && running; t++) begin
            cur_test    = t;
            base        = 1 + t * cols;
            errs_before = error_count;
            exp_cycles  = test_mem[base+4];
            exp_wb      = test_mem[base+6];
            exp_pc      = test_mem[base+7];
            instr    <= test_mem[base];                     // on the edge that ends fetch
            zero     <= test_mem[base+1][0];
            less     <= test_mem[base+2][0];
            overflow <= test_mem[base+3][0];
            if (exp_cycles == 0) begin
                observe(halt_watch);
                check_strobe("ir_load", 1'b0, fetched);
                running = 1'b0;                             // halted, only reset restarts
            end else begin
                observe(step_limit);
                if (!fetched) begin
                    $display("test %0d: no ir_load within %0d cycles", t, step_limit);
                    error_count++;
                    running = 1'b0;
                end else begin
                    check_cycles("fetch_to_fetch", exp_cycles, obs_cycles);
                    check_alu_op("alu_ctrl at fetch", alu_add, fetch_alu);
                    check_pc_src("pc_src at fetch", pc_alu_result, fetch_pc);
                    check_src_a("alu_src_a at fetch", src_a_pc, fetch_a);
                    check_src_b("alu_src_b at fetch", src_b_four, fetch_b);
                end
            end
            check_strobe("ab_write", 1'b1, obs_ab);
            check_strobe("alu_out_write", 1'b1, obs_aout);
            check_alu_op("alu_ctrl", alu_op_e'(test_mem[base+5][2:0]), obs_alu);
            check_strobe("reg_write", exp_wb != 7, wb_seen);
            if (exp_wb != 7) check_wb("wb_sel", wb_sel_e'(exp_wb[2:0]), obs_wb);
            if (exp_wb != 7 && wb_sel_e'(exp_wb[2:0]) == wb_shift) begin
                check_shift("shift_ctrl", shift_kind(test_mem[base]), obs_shift);
            end
            check_strobe("pc_write", exp_pc != 3, pc_seen);
            if (exp_pc != 3) check_pc_src("pc_src", pc_src_e'(exp_pc[1:0]), obs_pc);
            check_strobe("mem_write", test_mem[base+8][0], mem_cnt != 0);
            check_strobe("epc_write", test_mem[base+9][0], epc_cnt != 0);
            if (test_mem[base+9][0]) begin
                if (test_mem[base+3][0]) begin
                    exp_addr = addr_overflow_vec;
                end else begin
                    exp_addr = addr_illegal_vec;
                end
                check_addr("mem_addr_sel", exp_addr, obs_addr);
            end
            if (mem_cnt > 1 || epc_cnt > 1) begin
                $display("test %0d: mem_write or epc_write pulsed more than once", t);
                error_count++;
            end
            tests_run++;
            if (error_count != errs_before) tests_failed++;
            $display("test %0d instr %h: %s", t, test_mem[base],
                     (error_count == errs_before) ? "ok" : "mismatch");
        end

        $display("%0d of %0d tests run, %0d passed, %0d failed, %0d assertion errors",
                 tests_run, test_count, tests_run - tests_failed, tests_failed,
                 dut_i.assert_i.assert_errors);
        if (error_count == 0 && tests_run == test_count &&
            dut_i.assert_i.assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/ctrl_pkg.sv
logic/instr_decoder.sv
logic/ctrl_sequencer.sv
logic/ctrl_signal_gen.sv
logic/multicycle_ctrl.sv
verification/multicycle_ctrl_assert.sv
verification/multicycle_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: multicycle_ctrl

sources:
  - files:
      - logic/ctrl_pkg.sv
      - logic/instr_decoder.sv
      - logic/ctrl_sequencer.sv
      - logic/ctrl_signal_gen.sv
      - logic/multicycle_ctrl.sv
  - target: simulation
    files:
      - verification/multicycle_ctrl_assert.sv
      - verification/multicycle_ctrl_tb.sv

// ==== verification/ctrl_tests.txt ====
// first word is the number of tests, then one test per line:
// instr zero less overflow cycles alu_ctrl wb_sel(7 none) pc_src(3 none) mem_write epc_write
// cycles 0 means a halt is expected
17
00550533 0 0 0 5 1 0 3 0 0
40550533 0 0 0 5 2 0 3 0 0
00557533 0 0 0 5 3 0 3 0 0
00552533 0 1 0 5 5 1 3 0 0
00552513 0 0 0 5 5 2 3 0 0
00550513 0 0 0 5 1 0 3 0 0
00351513 0 0 0 4 0 5 3 0 0
40355513 0 0 0 4 0 5 3 0 0
00628863 1 0 0 4 2 7 1 0 0
00629863 1 0 0 4 2 7 3 0 0
0062c863 0 1 0 4 2 7 1 0 0
0062d863 0 1 0 4 4 7 3 0 0
0062d863 0 0 0 4 4 7 1 0 0
0082b503 0 0 0 8 1 4 3 0 0
00a2b423 0 0 0 7 1 7 3 1 0
12345537 0 0 0 5 1 0 3 0 0
008000ef 0 0 0 5 0 3 1 0 0
000280e7 0 0 0 5 1 3 1 0 0
0000000b 0 0 0 6 0 7 2 0 1
0082a503 0 0 0 6 0 7 2 0 1
00550533 0 0 1 6 1 7 2 0 1
00550513 0 0 1 6 1 7 2 0 1
00100073 0 0 0 0 0 7 3 0 0
